// File: src/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // ALU opcodes, codes 4 and 15 are reserved
    typedef enum logic [3:0] {
        opOr     = 4'd0,
        opAnd    = 4'd1,
        opAdd    = 4'd2,
        opMul    = 4'd3,
        opShl    = 4'd5,
        opLt     = 4'd6,
        opEq     = 4'd7,
        opGt     = 4'd8,
        opAndNot = 4'd9,
        opXor    = 4'd10,
        opSub    = 4'd11,
        opXnor   = 4'd12,
        opShr    = 4'd13,
        opNe     = 4'd14
    } aluOp_t;

    typedef enum logic [3:0] {
        stIdle,
        stFetch,
        stExec,
        stOperand,
        stMem,
        stCommit,
        stThrow,
        stVecLoad,
        stTrapSave,
        stTrapJump
    } coreState_t;

    // Instruction word layout, MSB first
    typedef struct packed {
        logic       spare;    // Only meaningful together with kind
        logic       kind;     // Swap Y and immediate
        logic       storing;
        logic       derefRhs;
        logic [3:0] rz;
        logic [3:0] rx;
        logic [3:0] ry;
        aluOp_t     op;
        logic [11:0] imm;
    } insnFields_t;

    typedef enum logic [1:0] {
        busFetch,
        busLoad,
        busStore
    } busKind_t;

    typedef struct packed {
        busKind_t    kind;
        logic [31:0] addr;
        logic [31:0] wdata;
    } busReq_t;

    typedef struct packed {
        logic        done;    // One-cycle completion pulse
        logic [31:0] rdata;
    } busRsp_t;

endpackage

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  cpuPkg::insnFields_t insn,
    output logic                throwFlag,
    output logic                branch,
    output logic                swap,
    output logic                storing,
    output logic                derefRhs,
    output logic [3:0]          rz,
    output logic [3:0]          rx,
    output logic [3:0]          ry,
    output cpuPkg::aluOp_t      op,
    output logic [31:0]         imm,
    output logic [4:0]          vector
);

    assign rz       = insn.rz;
    assign rx       = insn.rx;
    assign ry       = insn.ry;
    assign op       = insn.op;
    assign swap     = insn.kind;
    assign storing  = insn.storing;
    assign derefRhs = insn.derefRhs;

    assign imm    = {{20{insn.imm[11]}}, insn.imm};  // Sign extend
    assign vector = insn.imm[4:0];                   // Throw vector number

    // Both top bits set marks a software throw
    assign throwFlag = insn.spare & insn.kind;
    assign branch    = (insn.rz == 4'hF) & ~insn.storing;  // Writes r15

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        we,
    input  logic [3:0]  rz,
    input  logic [3:0]  rx,
    input  logic [3:0]  ry,
    input  logic [31:0] wdata,
    input  logic [31:0] nextPc,
    output logic [31:0] valueZ,
    output logic [31:0] valueX,
    output logic [31:0] valueY
);

    logic [31:0] regs [1:14];  // r1 to r14 only

    function automatic logic [31:0] readReg(input logic [3:0] idx, input logic [31:0] pcNext);
        logic [31:0] value;
        if (idx == 4'h0)
            value = 32'h0;     // r0 is zero
        else if (idx == 4'hF)
            value = pcNext;    // r15 is next PC
        else
            value = regs[idx];
        return value;
    endfunction

    assign valueZ = readReg(rz, nextPc);
    assign valueX = readReg(rx, nextPc);
    assign valueY = readReg(ry, nextPc);

    always_ff @(posedge clk) begin
        if (we && rz != 4'h0 && rz != 4'hF) begin
            regs[rz] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: src/aluExec.sv
`timescale 1ns/1ps
`default_nettype none

module aluExec (
    input  logic           clk,
    input  logic           en,
    input  logic           swap,
    input  cpuPkg::aluOp_t op,
    input  logic [31:0]    x,
    input  logic [31:0]    y,
    input  logic [31:0]    imm,
    output logic [31:0]    rhs
);

    logic [31:0] operand;
    logic [31:0] addend;
    logic [4:0]  shamt;
    logic        lessThan;
    logic        greaterThan;

    assign operand = swap ? imm : y;
    assign addend  = swap ? y : imm;
    assign shamt   = operand[4:0];

    // Signed compares
    assign lessThan    = $signed(x) < $signed(operand);
    assign greaterThan = $signed(x) > $signed(operand);

    always_ff @(posedge clk) begin
        if (en) begin
            case (op)
                cpuPkg::opOr:     rhs <= (x | operand) + addend;
                cpuPkg::opAnd:    rhs <= (x & operand) + addend;
                cpuPkg::opAdd:    rhs <= (x + operand) + addend;
                cpuPkg::opMul:    rhs <= (x * operand) + addend;  // Low 32 bits kept
                cpuPkg::opShl:    rhs <= (x << shamt) + addend;
                cpuPkg::opLt:     rhs <= {32{lessThan}} + addend;
                cpuPkg::opEq:     rhs <= {32{x == operand}} + addend;
                cpuPkg::opGt:     rhs <= {32{greaterThan}} + addend;
                cpuPkg::opAndNot: rhs <= (x & ~operand) + addend;
                cpuPkg::opXor:    rhs <= (x ^ operand) + addend;
                cpuPkg::opSub:    rhs <= (x - operand) + addend;
                cpuPkg::opXnor:   rhs <= (x ~^ operand) + addend;
                cpuPkg::opShr:    rhs <= (x >> shamt) + addend;   // Logical
                cpuPkg::opNe:     rhs <= {32{x != operand}} + addend;
                default:          rhs <= addend;                  // Reserved codes
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/busMaster.sv
`timescale 1ns/1ps
`default_nettype none

module busMaster (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            start,
    input  cpuPkg::busReq_t cmd,
    output cpuPkg::busRsp_t rsp,
    output cpuPkg::busReq_t busReq,
    output logic            req,
    input  logic            ack,
    input  logic [31:0]     rdata
);

    typedef enum logic [1:0] {
        bmIdle,
        bmWaitHigh,
        bmWaitLow
    } bmState_t;

    bmState_t        state;
    logic            done;
    logic [31:0]     rdataReg;
    cpuPkg::busReq_t cmdReg;

    assign busReq = cmdReg;    // Held for the whole handshake
    assign rsp    = '{done: done, rdata: rdataReg};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= bmIdle;
            req   <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                bmIdle: begin
                    if (start) begin
                        req   <= 1'b1;
                        state <= bmWaitHigh;
                    end
                end
                bmWaitHigh: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= bmWaitLow;
                    end
                end
                bmWaitLow: begin
                    if (!ack) begin
                        done  <= 1'b1;     // Cycle closed
                        state <= bmIdle;
                    end
                end
                default: state <= bmIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == bmIdle && start) begin
            cmdReg <= cmd;
        end
        if (state == bmWaitHigh && ack) begin
            rdataReg <= rdata;     // Valid while ack is high
        end
    end

endmodule

`default_nettype wire

// File: src/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
    parameter logic [31:0] resetVector  = 32'h0000_0100,
    parameter logic [31:0] vectorBase   = 32'h0000_0020,
    parameter logic [31:0] trampBase    = 32'h0000_0400,
    parameter logic [31:0] trapSaveAddr = 32'h0000_0030
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            trap,
    input  logic            halt,
    output logic            start,
    output cpuPkg::busReq_t cmd,
    input  cpuPkg::busRsp_t rsp
);

    cpuPkg::coreState_t  state;
    cpuPkg::insnFields_t insn;
    logic [31:0]         pc;
    logic [31:0]         nextPc;
    logic                issued;    // Bus transaction in flight
    logic                isTrap;

    logic [31:0] aluRes;
    logic [31:0] loadData;
    logic [31:0] handler;
    logic [31:0] commitValue;
    logic        busState;

    logic           throwFlag, branch, swap, storing, derefRhs;
    logic [3:0]     rz, rx, ry;
    cpuPkg::aluOp_t op;
    logic [31:0]    imm;
    logic [4:0]     vector;
    logic [31:0]    valueZ, valueX, valueY, aluRhs;

    assign nextPc      = pc + 32'd1;
    assign commitValue = derefRhs ? loadData : aluRes;

    instrDecoder decoder (
        .insn(insn), .throwFlag(throwFlag), .branch(branch), .swap(swap),
        .storing(storing), .derefRhs(derefRhs), .rz(rz), .rx(rx), .ry(ry),
        .op(op), .imm(imm), .vector(vector)
    );

    regFile regs (
        .clk(clk), .we(state == cpuPkg::stCommit && !storing),
        .rz(rz), .rx(rx), .ry(ry), .wdata(commitValue), .nextPc(nextPc),
        .valueZ(valueZ), .valueX(valueX), .valueY(valueY)
    );

    aluExec alu (
        .clk(clk), .en(state == cpuPkg::stExec), .swap(swap), .op(op),
        .x(valueX), .y(valueY), .imm(imm), .rhs(aluRhs)
    );

    assign busState = state inside {cpuPkg::stFetch, cpuPkg::stMem,
                                    cpuPkg::stVecLoad, cpuPkg::stTrapSave};
    assign start    = busState && !issued;

    always_comb begin
        cmd = '{kind: cpuPkg::busFetch, addr: pc, wdata: 32'h0};
        case (state)
            cpuPkg::stMem: begin
                cmd.kind  = storing ? cpuPkg::busStore : cpuPkg::busLoad;
                cmd.addr  = derefRhs ? aluRes : valueZ;  // Non-deref store goes to Z
                cmd.wdata = derefRhs ? valueZ : aluRes;
            end
            cpuPkg::stVecLoad: begin
                cmd.kind = cpuPkg::busLoad;
                cmd.addr = handler;                      // Vector table slot
            end
            cpuPkg::stTrapSave: begin
                cmd = '{kind: cpuPkg::busStore, addr: trapSaveAddr, wdata: pc};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state  <= cpuPkg::stIdle;
            pc     <= resetVector;
            issued <= 1'b0;
            isTrap <= 1'b0;
        end else begin
            if (start)
                issued <= 1'b1;
            else if (rsp.done)
                issued <= 1'b0;
            case (state)
                cpuPkg::stIdle: if (!halt) state <= cpuPkg::stFetch;
                cpuPkg::stFetch: if (rsp.done) state <= cpuPkg::stExec;
                cpuPkg::stExec: begin
                    isTrap <= trap;
                    if (halt)
                        state <= cpuPkg::stIdle;    // Refetch same PC later
                    else if (trap || throwFlag)
                        state <= cpuPkg::stThrow;
                    else
                        state <= cpuPkg::stOperand;
                end
                cpuPkg::stOperand:
                    state <= (storing || derefRhs) ? cpuPkg::stMem : cpuPkg::stCommit;
                cpuPkg::stMem: if (rsp.done) state <= cpuPkg::stCommit;
                cpuPkg::stCommit: begin
                    pc    <= (branch) ? commitValue : nextPc;
                    state <= cpuPkg::stFetch;
                end
                cpuPkg::stThrow:
                    state <= isTrap ? cpuPkg::stTrapSave : cpuPkg::stVecLoad;
                cpuPkg::stVecLoad: if (rsp.done) state <= cpuPkg::stTrapSave;
                cpuPkg::stTrapSave: if (rsp.done) state <= cpuPkg::stTrapJump;
                cpuPkg::stTrapJump: begin
                    pc    <= handler;
                    state <= cpuPkg::stFetch;
                end
                default: state <= cpuPkg::stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpuPkg::stFetch && rsp.done)
            insn <= cpuPkg::insnFields_t'(rsp.rdata);
        if (state == cpuPkg::stOperand)
            aluRes <= aluRhs;
        if (state == cpuPkg::stMem && rsp.done)
            loadData <= rsp.rdata;
        if (state == cpuPkg::stThrow)
            handler <= isTrap ? trampBase : (vectorBase | {27'h0, vector});
        if (state == cpuPkg::stVecLoad && rsp.done)
            handler <= rsp.rdata;                   // Handler address from table
    end

endmodule

`default_nettype wire

// File: src/cpuSystem.sv
`timescale 1ns/1ps
`default_nettype none

module cpuSystem #(
    parameter logic [31:0] resetVector  = 32'h0000_0100,
    parameter logic [31:0] vectorBase   = 32'h0000_0020,
    parameter logic [31:0] trampBase    = 32'h0000_0400,
    parameter logic [31:0] trapSaveAddr = 32'h0000_0030
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            trap,
    input  logic            halt,
    output cpuPkg::busReq_t busReq,
    output logic            req,
    input  logic            ack,
    input  logic [31:0]     rdata
);

    logic            start;
    cpuPkg::busReq_t cmd;
    cpuPkg::busRsp_t rsp;

    cpuCore #(
        .resetVector(resetVector),
        .vectorBase(vectorBase),
        .trampBase(trampBase),
        .trapSaveAddr(trapSaveAddr)
    ) core (
        .clk(clk),
        .reset_n(reset_n),
        .trap(trap),
        .halt(halt),
        .start(start),
        .cmd(cmd),
        .rsp(rsp)
    );

    busMaster master (
        .clk(clk),
        .reset_n(reset_n),
        .start(start),
        .cmd(cmd),
        .rsp(rsp),
        .busReq(busReq),
        .req(req),
        .ack(ack),
        .rdata(rdata)
    );

endmodule

`default_nettype wire

// File: tests/cpuSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuSystemTb;

    localparam logic [31:0] resetVector  = 32'h0000_0100;
    localparam logic [31:0] vectorBase   = 32'h0000_0020;
    localparam logic [31:0] trampBase    = 32'h0000_0400;
    localparam logic [31:0] trapSaveAddr = 32'h0000_0030;

    logic            clk;
    logic            reset_n;
    logic            trap;
    logic            halt;
    logic            req;
    logic            ack;
    logic [31:0]     rdata;
    cpuPkg::busReq_t busReq;

    cpuPkg::insnFields_t insnQ[$];      // Instruction stream served to fetches
    logic [31:0]         expFetch[$];
    logic [31:0]         fetchSeen[$];
    cpuPkg::busReq_t     expStore[$];
    cpuPkg::busReq_t     storeSeen[$];
    logic [31:0]         dataMem[logic [31:0]];
    logic [31:0]         shadowMem[logic [31:0]];
    logic [31:0]         shadowRegs[16];
    logic [31:0]         shadowPc;

    int errCount = 0;
    int testErrStart = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int issued = 0;
    int cycles = 0;

    cpuPkg::aluOp_t opList[14] = '{cpuPkg::opOr, cpuPkg::opAnd, cpuPkg::opAdd, cpuPkg::opMul,
        cpuPkg::opShl, cpuPkg::opLt, cpuPkg::opEq, cpuPkg::opGt, cpuPkg::opAndNot,
        cpuPkg::opXor, cpuPkg::opSub, cpuPkg::opXnor, cpuPkg::opShr, cpuPkg::opNe};

    cpuSystem #(
        .resetVector(resetVector),
        .vectorBase(vectorBase),
        .trampBase(trampBase),
        .trapSaveAddr(trapSaveAddr)
    ) DUT (
        .clk(clk), .reset_n(reset_n), .trap(trap), .halt(halt),
        .busReq(busReq), .req(req), .ack(ack), .rdata(rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Contents of data words never written
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return {addr[15:0] ^ 16'hA5C3, ~addr[31:16]} + addr;
    endfunction

    function automatic logic [31:0] memRead(input logic [31:0] addr);
        return shadowMem.exists(addr) ? shadowMem[addr] : fillWord(addr);
    endfunction

    function automatic logic [31:0] readShadow(input logic [3:0] idx);
        if (idx == 4'h0)
            return 32'h0;
        if (idx == 4'hF)
            return shadowPc + 32'd1;   // r15 is next instruction
        return shadowRegs[idx];
    endfunction

    function automatic logic [31:0] aluRef(input cpuPkg::aluOp_t op,
                                           input logic [31:0] x, o, a);
        logic [31:0] r;
        case (op)
            cpuPkg::opOr:     r = x | o;
            cpuPkg::opAnd:    r = x & o;
            cpuPkg::opAdd:    r = x + o;
            cpuPkg::opMul:    r = x * o;
            cpuPkg::opShl:    r = x << o[4:0];
            cpuPkg::opLt:     r = ($signed(x) < $signed(o)) ? 32'hFFFF_FFFF : 32'h0;
            cpuPkg::opEq:     r = (x == o) ? 32'hFFFF_FFFF : 32'h0;
            cpuPkg::opGt:     r = ($signed(x) > $signed(o)) ? 32'hFFFF_FFFF : 32'h0;
            cpuPkg::opAndNot: r = x & ~o;
            cpuPkg::opXor:    r = x ^ o;
            cpuPkg::opSub:    r = x - o;
            cpuPkg::opXnor:   r = x ~^ o;
            cpuPkg::opShr:    r = x >> o[4:0];
            default:          r = (x != o) ? 32'hFFFF_FFFF : 32'h0;
        endcase
        return r + a;
    endfunction

    // One instruction on the shadow state, returns the next fetch address
    function automatic logic [31:0] refExec(input cpuPkg::insnFields_t i,
                                            output logic hasStore,
                                            output cpuPkg::busReq_t st);
        logic [31:0] x, y, z, sImm, value, handler;
        hasStore = 1'b0;
        st = '{kind: cpuPkg::busFetch, addr: 32'h0, wdata: 32'h0};
        x = readShadow(i.rx);
        y = readShadow(i.ry);
        z = readShadow(i.rz);
        sImm = {{20{i.imm[11]}}, i.imm};
        if (i.spare && i.kind) begin
            handler = memRead(vectorBase | {27'h0, i.imm[4:0]});
            hasStore = 1'b1;
            st = '{kind: cpuPkg::busStore, addr: trapSaveAddr, wdata: shadowPc};
            shadowMem[trapSaveAddr] = shadowPc;
            return handler;
        end
        value = i.kind ? aluRef(i.op, x, sImm, y) : aluRef(i.op, x, y, sImm);
        if (i.storing) begin
            hasStore = 1'b1;
            st.kind  = cpuPkg::busStore;
            st.addr  = i.derefRhs ? value : z;
            st.wdata = i.derefRhs ? z : value;
            shadowMem[st.addr] = st.wdata;
            return shadowPc + 32'd1;
        end
        if (i.derefRhs)
            value = memRead(value);
        if (i.rz == 4'hF)
            return value;              // Branch
        if (i.rz != 4'h0)
            shadowRegs[i.rz] = value;
        return shadowPc + 32'd1;
    endfunction

    function automatic cpuPkg::insnFields_t makeInsn(input logic kind, storing, deref,
            input logic [3:0] rz, rx, ry, input cpuPkg::aluOp_t op, input logic [11:0] imm);
        return '{spare: 1'b0, kind: kind, storing: storing, derefRhs: deref,
                 rz: rz, rx: rx, ry: ry, op: op, imm: imm};
    endfunction

    task automatic checkFetch(input logic [31:0] expAddr, input logic [31:0] gotAddr);
        if (expAddr !== gotAddr) begin
            $display("ERR fetch busReq.addr exp %h got %h", expAddr, gotAddr);
            errCount++;
        end
    endtask

    task automatic checkStore(input cpuPkg::busReq_t expReq, input cpuPkg::busReq_t gotReq);
        if (expReq !== gotReq) begin
            $display("ERR store busReq exp addr %h wdata %h got kind %h addr %h wdata %h",
                     expReq.addr, expReq.wdata, gotReq.kind, gotReq.addr, gotReq.wdata);
            errCount++;
        end
    endtask

    task automatic setWord(input logic [31:0] addr, input logic [31:0] value);
        dataMem[addr]   = value;
        shadowMem[addr] = value;
    endtask

    task automatic issue(input cpuPkg::insnFields_t i);
        logic            hasStore;
        cpuPkg::busReq_t st;
        expFetch.push_back(shadowPc);
        shadowPc = refExec(i, hasStore, st);
        if (hasStore)
            expStore.push_back(st);
        insnQ.push_back(i);
        issued++;
    endtask

    task automatic drain();
        while (expFetch.size() != 0 || expStore.size() != 0)
            @(posedge clk);
    endtask

    task automatic endTest(input string name);
        drain();
        testsRun++;
        if (errCount == testErrStart) begin
            $display("%-8s ok", name);
        end else begin
            $display("%-8s FAILED with %0d mismatches", name, errCount - testErrStart);
            testsFailed++;
        end
        testErrStart = errCount;
    endtask

    // Memory side of the four-phase bus
    initial begin
        cpuPkg::busReq_t cur;
        forever begin
            @(posedge clk);
            if (req && !ack) begin
                cur = busReq;
                if (cur.kind == cpuPkg::busFetch) begin
                    fetchSeen.push_back(cur.addr);
                end else if (cur.kind == cpuPkg::busStore) begin
                    storeSeen.push_back(cur);
                    dataMem[cur.addr] = cur.wdata;
                end
                repeat ($urandom_range(3)) @(posedge clk);
                if (cur.kind == cpuPkg::busFetch) begin
                    while (insnQ.size() == 0)
                        @(posedge clk);        // Stall until the test supplies code
                    rdata <= insnQ.pop_front();
                end else if (cur.kind == cpuPkg::busLoad) begin
                    rdata <= dataMem.exists(cur.addr) ? dataMem[cur.addr] : fillWord(cur.addr);
                end
                ack <= 1'b1;
                do @(posedge clk); while (req);
                ack <= 1'b0;
            end
        end
    end

    // Compare actual bus traffic with the reference
    initial begin
        forever begin
            @(posedge clk);
            while (fetchSeen.size() != 0 && expFetch.size() != 0)
                checkFetch(expFetch.pop_front(), fetchSeen.pop_front());
            while (storeSeen.size() != 0 && expStore.size() != 0)
                checkStore(expStore.pop_front(), storeSeen.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 40 * issued + 200) begin
            $display("Timeout after %0d cycles, the DUT stopped finishing instructions", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        logic [11:0]         a, b, c;
        logic [31:0]         word;
        cpuPkg::insnFields_t thr;
        logic                reqSeen;
        void'($urandom(32'h72cb5900));
        reset_n = 1'b0;
        trap    = 1'b0;
        halt    = 1'b0;
        ack     = 1'b0;
        rdata   = 32'h0;
        shadowPc = resetVector;
        for (int r = 0; r < 16; r++)
            shadowRegs[r] = 32'h0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        for (int k = 0; k < 14; k++) begin
            a = $urandom;
            b = $urandom;
            c = $urandom;
            issue(makeInsn(0, 0, 0, 4'd1, 4'd0, 4'd0, cpuPkg::opOr, a));
            issue(makeInsn(0, 0, 0, 4'd2, 4'd0, 4'd0, cpuPkg::opOr, b));
            issue(makeInsn(0, 0, 0, 4'd3, 4'd1, 4'd2, opList[k], c));
            issue(makeInsn(0, 1, 1, 4'd3, 4'd0, 4'd0, cpuPkg::opOr, 12'h080));
        end
        endTest("aluOps");

        for (int k = 0; k < 8; k++) begin
            a = $urandom;
            b = $urandom;
            c = $urandom;
            issue(makeInsn(0, 0, 0, 4'd1, 4'd0, 4'd0, cpuPkg::opOr, a));
            issue(makeInsn(0, 0, 0, 4'd2, 4'd0, 4'd0, cpuPkg::opOr, b));
            issue(makeInsn(1, 0, 0, 4'd3, 4'd1, 4'd2, opList[$urandom_range(13)], c));
            issue(makeInsn(0, 1, 1, 4'd3, 4'd0, 4'd0, cpuPkg::opOr, 12'h080));
        end
        endTest("swapped");

        issue(makeInsn(0, 0, 0, 4'd1, 4'd0, 4'd0, cpuPkg::opOr, 12'h1F0));
        for (int k = 0; k < 6; k++) begin
            word = $urandom;
            if (k != 5)
                setWord(32'h200 + k, word);   // Last one reads the fill pattern
            issue(makeInsn(0, 0, 1, 4'd4, 4'd1, 4'd0, cpuPkg::opAdd, 12'h010 + k));
            issue(makeInsn(0, 1, 1, 4'd4, 4'd0, 4'd0, cpuPkg::opOr, 12'h084));
        end
        endTest("loads");

        issue(makeInsn(0, 0, 0, 4'd5, 4'd0, 4'd0, cpuPkg::opOr, 12'h300));
        issue(makeInsn(0, 0, 0, 4'd15, 4'd5, 4'd0, cpuPkg::opOr, 12'h000));
        issue('0);
        issue('0);
        issue(makeInsn(0, 0, 0, 4'd15, 4'd15, 4'd0, cpuPkg::opAdd, 12'h003));
        issue('0);
        issue(makeInsn(0, 0, 0, 4'd0, 4'd0, 4'd0, cpuPkg::opOr, 12'h055));
        issue(makeInsn(0, 1, 1, 4'd0, 4'd0, 4'd0, cpuPkg::opOr, 12'h088));
        issue('0);
        endTest("branch");

        setWord(vectorBase | 32'd5, 32'h500);
        thr = makeInsn(1, 0, 0, 4'd0, 4'd0, 4'd0, cpuPkg::opOr, 12'h005);
        thr.spare = 1'b1;
        issue(thr);
        drain();
        @(posedge clk);
        trap <= 1'b1;                  // Taken by the first word of the handler
        expFetch.push_back(shadowPc);
        expStore.push_back('{kind: cpuPkg::busStore, addr: trapSaveAddr, wdata: shadowPc});
        shadowMem[trapSaveAddr] = shadowPc;
        shadowPc = trampBase;
        insnQ.push_back(makeInsn(0, 1, 1, 4'd3, 4'd0, 4'd0, cpuPkg::opOr, 12'h08C));
        issued++;
        drain();
        @(posedge clk);
        trap <= 1'b0;
        expFetch.push_back(shadowPc);  // Trampoline fetch, its word comes in the halt test
        endTest("trap");

        @(posedge clk);
        halt <= 1'b1;
        insnQ.push_back('0);           // Fetched, then dropped at the halt check
        issued++;
        repeat (12) @(posedge clk);
        reqSeen = 1'b0;
        repeat (20) begin
            @(posedge clk);
            reqSeen = reqSeen | req;
        end
        if (reqSeen) begin
            $display("A bus request was raised while halt was held");
            errCount++;
        end
        halt <= 1'b0;
        issue(makeInsn(0, 0, 0, 4'd6, 4'd0, 4'd0, cpuPkg::opOr, 12'h077));
        issue(makeInsn(0, 1, 1, 4'd6, 4'd0, 4'd0, cpuPkg::opOr, 12'h090));
        issue('0);
        endTest("halt");

        repeat (5) @(posedge clk);
        if (storeSeen.size() != 0) begin
            $display("The DUT issued %0d stores that the reference did not expect",
                     storeSeen.size());
            errCount++;
        end
        $display("Tests run %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errCount);
        if (errCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: cpuSystem.f
src/cpuPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/aluExec.sv
src/busMaster.sv
src/cpuCore.sv
src/cpuSystem.sv
tests/cpuSystemTb.sv
